//--- logic/atop_slot_table.sv
// -----------------------------------------------
// Atomic slot table
// Per-slot B and R meta registers with busy flags
// Lowest free slot search, held under back-pressure
// -----------------------------------------------
module atop_slot_table import meta_pkg::*; #(
  parameter int unsigned NumSlots = 4
) (
  input  logic   clk_i,
  input  logic   rst_i,
  input  logic   alloc_i,
  input  logic   alloc_r_i,
  input  logic   stall_i,
  input  meta_t  meta_i,
  output id_dn_t slot_o,
  output logic   none_free_o,
  input  logic   b_pop_i,
  input  logic   r_pop_i,
  input  id_dn_t b_slot_i,
  input  id_dn_t r_slot_i,
  output meta_t  b_meta_o,
  output meta_t  r_meta_o
);

  localparam int unsigned SlotW = (NumSlots > 1) ? $clog2(NumSlots) : 1;

  typedef logic [SlotW-1:0] slot_idx_t;

  meta_t               b_mem_q [NumSlots];
  meta_t               r_mem_q [NumSlots];
  logic [NumSlots-1:0] b_busy_q, r_busy_q;
  logic [NumSlots-1:0] free_slots;
  id_dn_t              lowest_free, held_slot_q;
  logic                held_q;
  slot_idx_t           alloc_idx, b_idx, r_idx;

  // A slot is free only once both of its responses are gone
  assign free_slots  = ~(b_busy_q | r_busy_q);
  assign none_free_o = (free_slots == '0);

  always_comb begin
    lowest_free = '0;
    for (int i = NumSlots - 1; i >= 0; i--) begin
      if (free_slots[i]) begin
        lowest_free = id_dn_t'(i);
      end
    end
  end

  // Keep the offered ID stable while the AW waits for ready
  assign slot_o    = held_q ? held_slot_q : lowest_free;
  assign alloc_idx = slot_idx_t'(slot_o);
  assign b_idx     = slot_idx_t'(b_slot_i);
  assign r_idx     = slot_idx_t'(r_slot_i);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      held_q      <= 1'b0;
      held_slot_q <= '0;
      b_busy_q    <= '0;
      r_busy_q    <= '0;
    end else begin
      held_q      <= stall_i;
      held_slot_q <= slot_o;
      if (b_pop_i) begin
        b_busy_q[b_idx] <= 1'b0;
      end
      if (r_pop_i) begin
        r_busy_q[r_idx] <= 1'b0;
      end
      if (alloc_i) begin
        b_busy_q[alloc_idx] <= 1'b1;
        if (alloc_r_i) begin
          r_busy_q[alloc_idx] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc_i) begin
      b_mem_q[alloc_idx] <= meta_i;
      if (alloc_r_i) begin
        r_mem_q[alloc_idx] <= meta_i;
      end
    end
  end

  assign b_meta_o = b_mem_q[b_idx];
  assign r_meta_o = r_mem_q[r_idx];

endmodule

//--- logic/floo_meta_buffer.sv
// -----------------------------------------------
// Meta information buffer of the NoC chimney
// Downstream ID remapping, meta push and pop
// Valid and ready gating on full storage
// -----------------------------------------------
module floo_meta_buffer import meta_pkg::*; #(
  parameter int unsigned MaxTxns       = 4,
  parameter int unsigned MaxAtomicTxns = 4,
  parameter id_dn_t      NonAtopId     = '1
) (
  input  logic  clk_i,
  input  logic  rst_i,
  input  req_t  req_i,
  output rsp_t  rsp_o,
  output req_t  req_o,
  input  rsp_t  rsp_i,
  input  meta_t aw_meta_i,
  input  meta_t ar_meta_i,
  output meta_t b_meta_o,
  output meta_t r_meta_o
);

  // Response IDs below this value belong to atomic slots
  localparam id_up_t AtopIdLimit = id_up_t'(MaxAtomicTxns);
  localparam id_up_t FixedId     = id_up_t'(NonAtopId);

  meta_t  aw_rec, ar_rec;
  meta_t  fifo_b_meta, fifo_r_meta;
  meta_t  slot_b_meta, slot_r_meta;
  logic   aw_fifo_full, ar_fifo_full;
  logic   aw_fifo_empty, ar_fifo_empty;
  logic   aw_fifo_push, ar_fifo_push;
  logic   aw_fifo_pop, ar_fifo_pop;
  logic   is_atop_aw, atop_has_r, aw_room;
  logic   no_free_slot;
  id_dn_t atop_slot;
  logic   aw_hs, ar_hs, b_hs, r_last_hs;
  logic   is_atop_b, is_atop_r;

  // Meta records carry the upstream ID of their request
  always_comb begin
    aw_rec         = aw_meta_i;
    aw_rec.orig_id = req_i.aw.id;
    ar_rec         = ar_meta_i;
    ar_rec.orig_id = req_i.ar.id;
  end

  assign is_atop_aw = req_i.aw_valid && (req_i.aw.atop[5:4] != 2'b00);
  assign atop_has_r = req_i.aw.atop[AtopRResp];

  // Atomics need a free slot, other writes need room in the FIFO
  assign aw_room = is_atop_aw ? !no_free_slot : !aw_fifo_full;

  assign aw_hs     = req_o.aw_valid && rsp_i.aw_ready;
  assign ar_hs     = req_o.ar_valid && rsp_i.ar_ready;
  assign b_hs      = rsp_i.b_valid && req_i.b_ready;
  assign r_last_hs = rsp_i.r_valid && req_i.r_ready && rsp_i.r.last;

  assign is_atop_b = rsp_i.b_valid && (rsp_i.b.id < AtopIdLimit);
  assign is_atop_r = rsp_i.r_valid && (rsp_i.r.id < AtopIdLimit);

  assign aw_fifo_push = aw_hs && !is_atop_aw;
  assign ar_fifo_push = ar_hs;
  assign aw_fifo_pop  = b_hs && !is_atop_b && !aw_fifo_empty;
  // Only the last beat of a burst releases its record
  assign ar_fifo_pop  = r_last_hs && !is_atop_r && !ar_fifo_empty;

  meta_fifo #(
    .Depth     ( MaxTxns ),
    .payload_t ( meta_t  )
  ) u_aw_fifo (
    .clk_i   ( clk_i         ),
    .rst_i   ( rst_i         ),
    .push_i  ( aw_fifo_push  ),
    .data_i  ( aw_rec        ),
    .pop_i   ( aw_fifo_pop   ),
    .data_o  ( fifo_b_meta   ),
    .full_o  ( aw_fifo_full  ),
    .empty_o ( aw_fifo_empty )
  );

  meta_fifo #(
    .Depth     ( MaxTxns ),
    .payload_t ( meta_t  )
  ) u_ar_fifo (
    .clk_i   ( clk_i         ),
    .rst_i   ( rst_i         ),
    .push_i  ( ar_fifo_push  ),
    .data_i  ( ar_rec        ),
    .pop_i   ( ar_fifo_pop   ),
    .data_o  ( fifo_r_meta   ),
    .full_o  ( ar_fifo_full  ),
    .empty_o ( ar_fifo_empty )
  );

  atop_slot_table #(
    .NumSlots ( MaxAtomicTxns )
  ) u_slots (
    .clk_i       ( clk_i                                         ),
    .rst_i       ( rst_i                                         ),
    .alloc_i     ( aw_hs && is_atop_aw                           ),
    .alloc_r_i   ( atop_has_r                                    ),
    .stall_i     ( req_o.aw_valid && is_atop_aw && !rsp_i.aw_ready ),
    .meta_i      ( aw_rec                                        ),
    .slot_o      ( atop_slot                                     ),
    .none_free_o ( no_free_slot                                  ),
    .b_pop_i     ( b_hs && is_atop_b                             ),
    .r_pop_i     ( r_last_hs && is_atop_r                        ),
    .b_slot_i    ( id_dn_t'(rsp_i.b.id)                          ),
    .r_slot_i    ( id_dn_t'(rsp_i.r.id)                          ),
    .b_meta_o    ( slot_b_meta                                   ),
    .r_meta_o    ( slot_r_meta                                   )
  );

  assign b_meta_o = is_atop_b ? slot_b_meta : fifo_b_meta;
  assign r_meta_o = is_atop_r ? slot_r_meta : fifo_r_meta;

  always_comb begin
    req_o = req_i;
    rsp_o = rsp_i;
    // Fixed ID for ordinary requests, slot index for atomics
    req_o.ar.id    = FixedId;
    req_o.aw.id    = is_atop_aw ? id_up_t'(atop_slot) : FixedId;
    req_o.ar_valid = req_i.ar_valid && !ar_fifo_full;
    req_o.aw_valid = req_i.aw_valid && aw_room;
    rsp_o.ar_ready = rsp_i.ar_ready && !ar_fifo_full;
    rsp_o.aw_ready = rsp_i.aw_ready && aw_room;
    // Restore the upstream ID from the stored record
    rsp_o.b.id = b_meta_o.orig_id;
    rsp_o.r.id = r_meta_o.orig_id;
  end

endmodule

//--- logic/meta_buffer_top.sv
// -----------------------------------------------
// Top level of the meta information buffer
// Sets buffer depths and the fixed downstream ID
// -----------------------------------------------
module meta_buffer_top import meta_pkg::*; #(
  parameter int unsigned MaxTxns       = 4,
  parameter int unsigned MaxAtomicTxns = 4,
  parameter id_dn_t      NonAtopId     = 3'd7
) (
  input  logic  clk_i,
  input  logic  rst_i,
  input  req_t  req_i,
  output rsp_t  rsp_o,
  output req_t  req_o,
  input  rsp_t  rsp_i,
  input  meta_t aw_meta_i,
  input  meta_t ar_meta_i,
  output meta_t b_meta_o,
  output meta_t r_meta_o
);

  // Slot IDs must stay below the fixed non-atomic ID
  floo_meta_buffer #(
    .MaxTxns       ( MaxTxns       ),
    .MaxAtomicTxns ( MaxAtomicTxns ),
    .NonAtopId     ( NonAtopId     )
  ) u_buffer (
    .clk_i     ( clk_i     ),
    .rst_i     ( rst_i     ),
    .req_i     ( req_i     ),
    .rsp_o     ( rsp_o     ),
    .req_o     ( req_o     ),
    .rsp_i     ( rsp_i     ),
    .aw_meta_i ( aw_meta_i ),
    .ar_meta_i ( ar_meta_i ),
    .b_meta_o  ( b_meta_o  ),
    .r_meta_o  ( r_meta_o  )
  );

endmodule

//--- logic/meta_fifo.sv
// -----------------------------------------------
// In-order FIFO for buffered meta records
// Circular buffer with occupancy count
// -----------------------------------------------
module meta_fifo #(
  parameter int unsigned Depth     = 4,
  parameter type         payload_t = logic
) (
  input  logic     clk_i,
  input  logic     rst_i,
  input  logic     push_i,
  input  payload_t data_i,
  input  logic     pop_i,
  output payload_t data_o,
  output logic     full_o,
  output logic     empty_o
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  typedef logic [PtrW-1:0] ptr_t;

  localparam ptr_t LastPtr = ptr_t'(Depth - 1);

  payload_t        mem_q [Depth];
  ptr_t            wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0] count_q;
  logic            do_push, do_pop;

  assign full_o  = (count_q == CntW'(Depth));
  assign empty_o = (count_q == '0);

  // A full FIFO still takes a push when the head leaves in the same cycle
  assign do_pop  = pop_i && !empty_o;
  assign do_push = push_i && (!full_o || do_pop);

  // Head of queue, oldest entry
  assign data_o = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= (wr_ptr_q == LastPtr) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == LastPtr) ? '0 : rd_ptr_q + 1'b1;
      end
      if (do_push && !do_pop) begin
        count_q <= count_q + 1'b1;
      end else if (do_pop && !do_push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

endmodule

//--- logic/meta_pkg.sv
// -----------------------------------------------
// Shared types of the meta information buffer
// ID, address and meta record types
// AXI-style channel structs and request bundles
// -----------------------------------------------
package meta_pkg;

  typedef logic [3:0]  id_up_t;
  typedef logic [2:0]  id_dn_t;
  typedef logic [31:0] addr_t;
  typedef logic [5:0]  atop_t;

  // Atomic that also returns read data
  localparam int unsigned AtopRResp = 5;

  typedef struct packed {
    id_up_t     orig_id;
    logic [5:0] src_id;
    logic [7:0] route_hdr;
  } meta_t;

  typedef struct packed {
    id_up_t id;
    addr_t  addr;
    atop_t  atop;
  } aw_chan_t;

  typedef struct packed {
    id_up_t id;
    addr_t  addr;
  } ar_chan_t;

  typedef struct packed {
    id_up_t     id;
    logic [1:0] resp;
  } b_chan_t;

  typedef struct packed {
    id_up_t      id;
    logic [31:0] data;
    logic [1:0]  resp;
    logic        last;
  } r_chan_t;

  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    ar_chan_t ar;
    logic     ar_valid;
    logic     b_ready;
    logic     r_ready;
  } req_t;

  typedef struct packed {
    logic    aw_ready;
    logic    ar_ready;
    b_chan_t b;
    logic    b_valid;
    r_chan_t r;
    logic    r_valid;
  } rsp_t;

endpackage

//--- meta_buffer_top.f
logic/meta_pkg.sv
logic/meta_fifo.sv
logic/atop_slot_table.sv
logic/floo_meta_buffer.sv
logic/meta_buffer_top.sv
sim/meta_buffer_props.sv
sim/meta_checker.sv
sim/tb_meta_buffer.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the meta buffer testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert \
    --top-module tb_meta_buffer -Mdir obj_dir -f meta_buffer_top.f; then
  echo "Verilator build failed"
  exit 1
fi

output=$(./obj_dir/Vtb_meta_buffer)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "ALL CHECKS PASSED" <<< "$output"; then
  exit 0
else
  echo "Pass message not found in simulation output"
  exit 1
fi

//--- sim/meta_buffer_props.sv
// -----------------------------------------------
// Concurrent assertions on the meta buffer
// Bound into every floo_meta_buffer instance
// -----------------------------------------------
module meta_buffer_props import meta_pkg::*; (
  input logic       clk_i,
  input logic       rst_i,
  input req_t       req_o,
  input rsp_t       rsp_i,
  input logic       aw_fifo_empty_i,
  input logic       ar_fifo_empty_i,
  input logic       is_atop_b_i,
  input logic       is_atop_r_i,
  input logic       no_free_slot_i,
  input logic [3:0] b_busy_i,
  input logic [3:0] r_busy_i
);

  // Responses need stored meta data
  assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_i.b_valid && !is_atop_b_i |-> !aw_fifo_empty_i) else $error("B for empty FIFO");
  assert property (@(posedge clk_i) disable iff (rst_i)
    rsp_i.r_valid && !is_atop_r_i |-> !ar_fifo_empty_i) else $error("R for empty FIFO");
  assert property (@(posedge clk_i) disable iff (rst_i)
    is_atop_b_i |-> b_busy_i[rsp_i.b.id[1:0]]) else $error("B for unused slot");
  assert property (@(posedge clk_i) disable iff (rst_i)
    is_atop_r_i |-> r_busy_i[rsp_i.r.id[1:0]]) else $error("R for unused slot");

  // A back-pressured AW keeps its ID
  assert property (@(posedge clk_i) disable iff (rst_i)
    req_o.aw_valid && !rsp_i.aw_ready |=> $stable(req_o.aw.id)) else $error("AW ID moved");

  // Storage holds nothing once reset ends
  assert property (@(posedge clk_i)
    $fell(rst_i) |-> aw_fifo_empty_i && ar_fifo_empty_i && !no_free_slot_i)
    else $error("Storage not clear after reset");

endmodule

bind floo_meta_buffer meta_buffer_props u_props (
  .clk_i           ( clk_i             ),
  .rst_i           ( rst_i             ),
  .req_o           ( req_o             ),
  .rsp_i           ( rsp_i             ),
  .aw_fifo_empty_i ( aw_fifo_empty     ),
  .ar_fifo_empty_i ( ar_fifo_empty     ),
  .is_atop_b_i     ( is_atop_b         ),
  .is_atop_r_i     ( is_atop_r         ),
  .no_free_slot_i  ( no_free_slot      ),
  .b_busy_i        ( u_slots.b_busy_q  ),
  .r_busy_i        ( u_slots.r_busy_q  )
);

//--- sim/meta_checker.sv
// -----------------------------------------------
// Scoreboard for the meta buffer
// Reference model of FIFOs and atomic slots
// Compares IDs, gating, meta data and pass-through fields
// -----------------------------------------------
module meta_checker import meta_pkg::*; #(
  parameter int unsigned MaxTxns       = 4,
  parameter int unsigned MaxAtomicTxns = 4
) (
  input  logic  clk_i,
  input  logic  rst_i,
  input  req_t  up_req_i,
  input  rsp_t  up_rsp_i,
  input  req_t  dn_req_i,
  input  rsp_t  dn_rsp_i,
  input  meta_t aw_meta_i,
  input  meta_t ar_meta_i,
  input  meta_t b_meta_i,
  input  meta_t r_meta_i,
  output int    errors_o,
  output int    checks_o
);

  localparam id_dn_t     FixedId  = 3'd7;
  localparam logic [7:0] SlotMask = 8'((1 << MaxAtomicTxns) - 1);

  meta_t      wq[$];
  meta_t      rq[$];
  meta_t      b_mem [8];
  meta_t      r_mem [8];
  logic [7:0] b_busy, r_busy, free;
  logic       held, atomic, stall, aw_room, ar_room, b_atop, r_atop;
  id_dn_t     held_id, exp_id, b_dn, r_dn;
  meta_t      exp_b, exp_r, rec;

  initial begin
    errors_o = 0;
    checks_o = 0;
  end

  // Expected downstream ID of the AW currently offered
  function automatic id_dn_t expect_dn_id(logic is_atop, logic [7:0] free_slots,
                                          logic is_held, id_dn_t last_id);
    id_dn_t id;
    id = FixedId;
    if (is_atop && is_held) begin
      id = last_id;
    end else if (is_atop) begin
      for (int i = int'(MaxAtomicTxns) - 1; i >= 0; i--) begin
        if (free_slots[i]) begin
          id = id_dn_t'(i);
        end
      end
    end
    return id;
  endfunction

  function automatic meta_t make_record(meta_t m, id_up_t id);
    meta_t r;
    r = m;
    r.orig_id = id;
    return r;
  endfunction

  task automatic check_value(logic ok, string what);
    checks_o++;
    if (!ok) begin
      errors_o++;
      $display("CHECK FAILED at %0t: %s", $time, what);
    end
  endtask

  task automatic report_error(string what);
    errors_o++;
    $display("Error at %0t: %s", $time, what);
  endtask

  always @(posedge clk_i) begin
    if (rst_i) begin
      wq.delete();
      rq.delete();
      b_busy  = '0;
      r_busy  = '0;
      held    = 1'b0;
      held_id = '0;
    end else begin
      atomic  = up_req_i.aw_valid && (up_req_i.aw.atop[5:4] != 2'b00);
      free    = ~(b_busy | r_busy) & SlotMask;
      aw_room = atomic ? (free != '0) : (wq.size() < int'(MaxTxns));
      ar_room = rq.size() < int'(MaxTxns);
      check_value(dn_req_i.aw_valid == (up_req_i.aw_valid && aw_room), "AW valid gating");
      check_value(up_rsp_i.aw_ready == (dn_rsp_i.aw_ready && aw_room), "AW ready gating");
      check_value(dn_req_i.ar_valid == (up_req_i.ar_valid && ar_room), "AR valid gating");
      check_value(up_rsp_i.ar_ready == (dn_rsp_i.ar_ready && ar_room), "AR ready gating");
      exp_id = expect_dn_id(atomic, free, held, held_id);
      if (dn_req_i.aw_valid) begin
        check_value(dn_req_i.aw.id == id_up_t'(exp_id), $sformatf(
          "AW downstream ID %0d, expected %0d", dn_req_i.aw.id, exp_id));
        check_value(dn_req_i.aw.addr == up_req_i.aw.addr, "AW address not passed downstream");
        check_value(dn_req_i.aw.atop == up_req_i.aw.atop, "AW atop not passed downstream");
      end
      if (dn_req_i.ar_valid) begin
        check_value(dn_req_i.ar.id == id_up_t'(FixedId), "AR downstream ID not fixed");
        check_value(dn_req_i.ar.addr == up_req_i.ar.addr, "AR address not passed downstream");
      end
      stall = dn_req_i.aw_valid && atomic && !dn_rsp_i.aw_ready;

      // Handshake and payload fields that pass through unchanged
      check_value(up_rsp_i.b_valid == dn_rsp_i.b_valid, "B valid not passed upstream");
      check_value(up_rsp_i.r_valid == dn_rsp_i.r_valid, "R valid not passed upstream");
      check_value(dn_req_i.b_ready == up_req_i.b_ready, "B ready not passed downstream");
      check_value(dn_req_i.r_ready == up_req_i.r_ready, "R ready not passed downstream");
      if (dn_rsp_i.r_valid) begin
        check_value(up_rsp_i.r.data == dn_rsp_i.r.data, "R data not passed upstream");
        check_value(up_rsp_i.r.last == dn_rsp_i.r.last, "R last not passed upstream");
      end

      // B and R meta data on every valid beat
      b_dn   = id_dn_t'(dn_rsp_i.b.id);
      b_atop = dn_rsp_i.b.id < id_up_t'(MaxAtomicTxns);
      if (dn_rsp_i.b_valid) begin
        exp_b = '0;
        if (b_atop && !b_busy[b_dn]) begin
          report_error("B response for an unused atomic slot");
        end else if (b_atop) begin
          exp_b = b_mem[b_dn];
        end else if (wq.size() == 0) begin
          report_error("B response with no outstanding write");
        end else begin
          exp_b = wq[0];
        end
        check_value(b_meta_i == exp_b, $sformatf("B meta %h, expected %h", b_meta_i, exp_b));
        check_value(up_rsp_i.b.id == exp_b.orig_id, $sformatf(
          "B upstream ID %0d, expected %0d", up_rsp_i.b.id, exp_b.orig_id));
      end
      r_dn   = id_dn_t'(dn_rsp_i.r.id);
      r_atop = dn_rsp_i.r.id < id_up_t'(MaxAtomicTxns);
      if (dn_rsp_i.r_valid) begin
        exp_r = '0;
        if (r_atop && !r_busy[r_dn]) begin
          report_error("R response for an unused atomic slot");
        end else if (r_atop) begin
          exp_r = r_mem[r_dn];
        end else if (rq.size() == 0) begin
          report_error("R response with no outstanding read");
        end else begin
          exp_r = rq[0];
        end
        check_value(r_meta_i == exp_r, $sformatf("R meta %h, expected %h", r_meta_i, exp_r));
        check_value(up_rsp_i.r.id == exp_r.orig_id, $sformatf(
          "R upstream ID %0d, expected %0d", up_rsp_i.r.id, exp_r.orig_id));
      end

      // Pops first, then pushes of this edge
      if (dn_rsp_i.b_valid && dn_req_i.b_ready) begin
        if (b_atop) begin
          b_busy[b_dn] = 1'b0;
        end else if (wq.size() > 0) begin
          void'(wq.pop_front());
        end
      end
      if (dn_rsp_i.r_valid && dn_req_i.r_ready && dn_rsp_i.r.last) begin
        if (r_atop) begin
          r_busy[r_dn] = 1'b0;
        end else if (rq.size() > 0) begin
          void'(rq.pop_front());
        end
      end
      if (dn_req_i.aw_valid && dn_rsp_i.aw_ready) begin
        rec = make_record(aw_meta_i, up_req_i.aw.id);
        if (atomic) begin
          b_busy[exp_id] = 1'b1;
          b_mem[exp_id]  = rec;
          if (up_req_i.aw.atop[AtopRResp]) begin
            r_busy[exp_id] = 1'b1;
            r_mem[exp_id]  = rec;
          end
        end else begin
          wq.push_back(rec);
        end
      end
      if (dn_req_i.ar_valid && dn_rsp_i.ar_ready) begin
        rq.push_back(make_record(ar_meta_i, up_req_i.ar.id));
      end
      held    = stall;
      held_id = exp_id;
    end
  end

endmodule

//--- sim/tb_meta_buffer.sv
// -----------------------------------------------
// Testbench of the meta buffer
// Random upstream requester and downstream target
// Target reorders atomics against ordinary traffic
// -----------------------------------------------
module tb_meta_buffer import meta_pkg::*; ();

  logic       clk, rst;
  req_t       up_req, dn_req;
  rsp_t       up_rsp, dn_rsp;
  meta_t      aw_meta, ar_meta, b_meta, r_meta;
  int         errors, checks, wr_cnt, rd_cnt, r_beats, drain;
  logic [7:0] slot_b, slot_r;

  meta_buffer_top u_dut (
    .clk_i     ( clk     ),
    .rst_i     ( rst     ),
    .req_i     ( up_req  ),
    .rsp_o     ( up_rsp  ),
    .req_o     ( dn_req  ),
    .rsp_i     ( dn_rsp  ),
    .aw_meta_i ( aw_meta ),
    .ar_meta_i ( ar_meta ),
    .b_meta_o  ( b_meta  ),
    .r_meta_o  ( r_meta  )
  );

  meta_checker u_checker (
    .clk_i     ( clk     ),
    .rst_i     ( rst     ),
    .up_req_i  ( up_req  ),
    .up_rsp_i  ( up_rsp  ),
    .dn_req_i  ( dn_req  ),
    .dn_rsp_i  ( dn_rsp  ),
    .aw_meta_i ( aw_meta ),
    .ar_meta_i ( ar_meta ),
    .b_meta_i  ( b_meta  ),
    .r_meta_i  ( r_meta  ),
    .errors_o  ( errors  ),
    .checks_o  ( checks  )
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic start_aw();
    up_req.aw.id   = 4'($urandom);
    up_req.aw.addr = $urandom;
    // About a third of the writes are atomics
    if ($urandom % 3 == 0) begin
      up_req.aw.atop = {2'(1 + $urandom % 3), 4'($urandom)};
    end else begin
      up_req.aw.atop = {2'b00, 4'($urandom)};
    end
    aw_meta         = meta_t'(18'($urandom));
    up_req.aw_valid = 1'b1;
  endtask

  task automatic start_ar();
    up_req.ar.id    = 4'($urandom);
    up_req.ar.addr  = $urandom;
    ar_meta         = meta_t'(18'($urandom));
    up_req.ar_valid = 1'b1;
  endtask

  // Pick a pending response, ordinary ones only from the head
  function automatic int pick_response(int ordinary, logic [7:0] slots);
    int cands[$];
    if (ordinary > 0) begin
      cands.push_back(7);
    end
    for (int s = 0; s < 8; s++) begin
      if (slots[s]) begin
        cands.push_back(s);
      end
    end
    if (cands.size() == 0) begin
      return -1;
    end
    return cands[$urandom % cands.size()];
  endfunction

  task automatic cycle_step(input bit issue);
    bit aw_up_hs, ar_up_hs, aw_dn_hs, ar_dn_hs, b_dn_hs, r_dn_hs;
    int pick;
    @(posedge clk);
    aw_up_hs = up_req.aw_valid && up_rsp.aw_ready;
    ar_up_hs = up_req.ar_valid && up_rsp.ar_ready;
    aw_dn_hs = dn_req.aw_valid && dn_rsp.aw_ready;
    ar_dn_hs = dn_req.ar_valid && dn_rsp.ar_ready;
    b_dn_hs  = dn_rsp.b_valid && dn_req.b_ready;
    r_dn_hs  = dn_rsp.r_valid && dn_req.r_ready;
    if (aw_dn_hs && dn_req.aw.id == 4'd7) begin
      wr_cnt++;
    end else if (aw_dn_hs) begin
      slot_b[dn_req.aw.id[2:0]] = 1'b1;
      slot_r[dn_req.aw.id[2:0]] = dn_req.aw.atop[AtopRResp];
    end
    if (ar_dn_hs) begin
      rd_cnt++;
    end
    #1;
    if (aw_up_hs) begin
      up_req.aw_valid = 1'b0;
    end
    if (ar_up_hs) begin
      up_req.ar_valid = 1'b0;
    end
    if (issue && !up_req.aw_valid && $urandom % 3 == 0) begin
      start_aw();
    end
    if (issue && !up_req.ar_valid && $urandom % 3 == 0) begin
      start_ar();
    end
    up_req.b_ready   = ($urandom % 4 != 0);
    up_req.r_ready   = ($urandom % 4 != 0);
    dn_rsp.aw_ready  = 1'($urandom % 2);
    dn_rsp.ar_ready  = 1'($urandom % 2);
    if (b_dn_hs) begin
      dn_rsp.b_valid = 1'b0;
    end
    if (!dn_rsp.b_valid && $urandom % 4 == 0) begin
      pick = pick_response(wr_cnt, slot_b);
      if (pick == 7) begin
        wr_cnt--;
      end else if (pick >= 0) begin
        slot_b[pick] = 1'b0;
      end
      if (pick >= 0) begin
        dn_rsp.b.id    = 4'(pick);
        dn_rsp.b.resp  = 2'b00;
        dn_rsp.b_valid = 1'b1;
      end
    end
    if (r_dn_hs && dn_rsp.r.last) begin
      dn_rsp.r_valid = 1'b0;
    end else if (r_dn_hs) begin
      r_beats--;
      dn_rsp.r.last = (r_beats == 1);
      dn_rsp.r.data = $urandom;
    end
    if (!dn_rsp.r_valid && $urandom % 4 == 0) begin
      pick = pick_response(rd_cnt, slot_r);
      if (pick == 7) begin
        rd_cnt--;
      end else if (pick >= 0) begin
        slot_r[pick] = 1'b0;
      end
      if (pick >= 0) begin
        r_beats        = 1 + int'($urandom % 3);
        dn_rsp.r.id    = 4'(pick);
        dn_rsp.r.data  = $urandom;
        dn_rsp.r.resp  = 2'b00;
        dn_rsp.r.last  = (r_beats == 1);
        dn_rsp.r_valid = 1'b1;
      end
    end
  endtask

  function automatic bit all_idle();
    return !up_req.aw_valid && !up_req.ar_valid && !dn_rsp.b_valid && !dn_rsp.r_valid &&
           wr_cnt == 0 && rd_cnt == 0 && slot_b == '0 && slot_r == '0;
  endfunction

  initial begin
    void'($urandom(32'h453e));
    up_req  = '0;
    dn_rsp  = '0;
    aw_meta = '0;
    ar_meta = '0;
    wr_cnt  = 0;
    rd_cnt  = 0;
    r_beats = 0;
    slot_b  = '0;
    slot_r  = '0;
    rst     = 1'b1;
    repeat (16) @(posedge clk);
    #1 rst = 1'b0;
    for (int cyc = 0; cyc < 4000; cyc++) begin
      cycle_step(1'b1);
    end
    // Let every outstanding transaction complete
    drain = 0;
    while (!all_idle() && drain < 2000) begin
      cycle_step(1'b0);
      drain++;
    end
    if (!all_idle()) begin
      $display("Timeout: outstanding transactions did not complete");
      $display("CHECKS FAILED");
    end else begin
      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
        $display("ALL CHECKS PASSED");
      end else begin
        $display("CHECKS FAILED");
      end
    end
    $finish;
  end

endmodule
